// ==== apbPkg.sv ====
//////////////////////////////
// APB register offsets, field and status bit positions
// Register-select type for the address decoder
//////////////////////////////
package apbPkg;

	// Word register byte offsets
	localparam logic [31:0] addrTxData  = 32'd0;
	localparam logic [31:0] addrStatus  = 32'd4;
	localparam logic [31:0] addrConfig  = 32'd8;
	localparam logic [31:0] addrIrqMask = 32'd12;

	// Config register: SCL divider in the low bits, enable above it
	localparam int divWidth     = 14;
	localparam int cfgEnableBit = 14;

	// Status bit positions
	localparam int stTxEmpty  = 0;
	localparam int stBusy     = 1;
	localparam int stNack     = 2;
	// FIFO fill level starts here
	localparam int stLevelLsb = 8;

	// Framing flags in a transmit data word, byte in bits 7:0
	localparam int txStartBit = 8;
	localparam int txStopBit  = 9;

	// Decoded target of an APB access
	typedef enum logic [2:0] {regTx, regStatus, regConfig, regMask, regNone} regSel_e;

endpackage

// ==== i2cPkg.sv ====
//////////////////////////////
// Transmit FIFO sizing, FIFO word type
// and bus engine states
//////////////////////////////
package i2cPkg;

	// Transmit FIFO entries
	localparam int fifoDepth  = 4;
	// Fill level width, holds 0 up to fifoDepth
	localparam int levelWidth = 3;

	// One queued byte with its framing
	typedef struct packed {
		logic [7:0] data;
		// Issue a start (or repeated start) before the byte
		logic       start;
		// Issue a stop after the ACK
		logic       stop;
	} i2cByte_t;

	// Bus engine states
	typedef enum logic [2:0] {
		sIdle,
		sStart,
		sBit,
		sAck,
		sStop,
		// Bus owned, SCL low, waiting for the next byte
		sHold
	} i2cState_e;

endpackage

// ==== i2cByteIf.sv ====
//////////////////////////////
// Valid/ready byte channel with fill level
//////////////////////////////
`timescale 1ns/1ns

interface i2cByteIf
	import i2cPkg::*;
();

	// Handshake, transfer on an edge with both high
	logic                  valid;
	logic                  ready;
	// Byte plus start/stop flags, held with valid until taken
	i2cByte_t              item;
	// Fill level reported by the receiving side
	logic [levelWidth-1:0] level;

	// Source of bytes
	modport producer (output valid, output item, input ready, input level);

	// Sink of bytes, also reports its level
	modport consumer (input valid, input item, output ready, output level);

endinterface

// ==== apbRegs.sv ====
//////////////////////////////
// APB slave register block
// Decode, config and mask registers, TX push, status, irq
//////////////////////////////
`timescale 1ns/1ns

module apbRegs
	import apbPkg::*, i2cPkg::*;
(
	input  logic                PCLK,
	input  logic                PRESETn,
	input  logic                PSEL,
	input  logic                PENABLE,
	input  logic                PWRITE,
	input  logic [31:0]         PADDR,
	input  logic [31:0]         PWDATA,
	input  logic                busy,
	input  logic                nackPulse,
	output logic [31:0]         PRDATA,
	output logic                PREADY,
	output logic                PSLVERR,
	output logic [divWidth-1:0] divider,
	output logic                enable,
	output logic                irq,
	i2cByteIf.producer          pushIf
);

	regSel_e               regSel;
	logic                  access;
	logic                  txWrite;
	logic                  wrDone;
	logic                  txEmpty;
	logic [cfgEnableBit:0] cfgReg;
	logic [1:0]            maskReg;
	logic                  nackFlag;
	logic [31:0]           statusWord;

	//////////////////////////////
	// Access decode
	//////////////////////////////

	// Map the offset onto a register, anything else errors
	always_comb
	begin
		case (PADDR)
			addrTxData:  regSel = regTx;
			addrStatus:  regSel = regStatus;
			addrConfig:  regSel = regConfig;
			addrIrqMask: regSel = regMask;
			default:     regSel = regNone;
		endcase
	end

	// Second APB phase
	assign access  = PSEL && PENABLE;
	assign txWrite = access && PWRITE && (regSel == regTx);

	// Only a TX write can wait, until the FIFO has room
	assign PREADY  = access && (!txWrite || pushIf.ready);
	assign PSLVERR = access && (regSel == regNone);
	// Write that completes on this edge
	assign wrDone  = access && PWRITE && PREADY;

	// Push held with the stretched access, taken when PREADY rises
	assign pushIf.valid = txWrite;
	assign pushIf.item  = '{data: PWDATA[7:0], start: PWDATA[txStartBit],
		stop: PWDATA[txStopBit]};

	//////////////////////////////
	// Registers
	//////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfgReg   <= '0;
			maskReg  <= '0;
			nackFlag <= 1'b0;
		end
		else
		begin
			// Divider and enable, upper bits dropped
			if (wrDone && (regSel == regConfig))
				cfgReg <= PWDATA[cfgEnableBit:0];
			// Two interrupt sources
			if (wrDone && (regSel == regMask))
				maskReg <= PWDATA[1:0];
			// Sticky NACK, a new NACK beats a clear in the same cycle
			if (nackPulse)
				nackFlag <= 1'b1;
			else if (wrDone && (regSel == regStatus) && PWDATA[stNack])
				nackFlag <= 1'b0;
		end
	end

	assign divider = cfgReg[divWidth-1:0];
	assign enable  = cfgReg[cfgEnableBit];

	//////////////////////////////
	// Status, read data, interrupt
	//////////////////////////////

	// Nothing queued and nothing on the wire
	assign txEmpty = (pushIf.level == '0) && !busy;

	always_comb
	begin
		statusWord                           = '0;
		statusWord[stTxEmpty]                = txEmpty;
		statusWord[stBusy]                   = busy;
		statusWord[stNack]                   = nackFlag;
		statusWord[stLevelLsb +: levelWidth] = pushIf.level;
	end

	// TX data is write only and reads as zero
	always_comb
	begin
		case (regSel)
			regStatus: PRDATA = statusWord;
			regConfig: PRDATA = 32'(cfgReg);
			regMask:   PRDATA = 32'(maskReg);
			default:   PRDATA = '0;
		endcase
	end

	// Mask bit 0 for empty, bit 1 for NACK
	assign irq = (maskReg[0] && txEmpty) || (maskReg[1] && nackFlag);

	// Access phase entered only from a setup phase
	apbSetupFirst: assert property (@(posedge PCLK) disable iff (!PRESETn)
		(PSEL && $rose(PENABLE)) |-> $past(PSEL));

	// Master keeps the address during wait states
	apbAddrStable: assert property (@(posedge PCLK) disable iff (!PRESETn)
		(PSEL && PENABLE && !PREADY) |=> $stable(PADDR));

endmodule

// ==== txFifo.sv ====
//////////////////////////////
// Synchronous transmit FIFO with fill level
//////////////////////////////
`timescale 1ns/1ns

module txFifo
	import i2cPkg::*;
#(
	parameter int depth = fifoDepth
)
(
	input  logic       PCLK,
	input  logic       PRESETn,
	i2cByteIf.consumer pushIf,
	i2cByteIf.producer popIf
);

	// Storage, payload only
	i2cByte_t                   mem [depth];
	logic [$clog2(depth)-1:0]   wrPtr;
	logic [$clog2(depth)-1:0]   rdPtr;
	logic [levelWidth-1:0]      count;
	logic                       push;
	logic                       pop;

	// Handshakes on both sides
	assign push = pushIf.valid && pushIf.ready;
	assign pop  = popIf.valid && popIf.ready;

	// Room left, level back to the register block
	assign pushIf.ready = (count < depth);
	assign pushIf.level = count;

	// Head entry offered as soon as anything is stored
	assign popIf.valid = (count != '0);
	assign popIf.item  = mem[rdPtr];

	//////////////////////////////
	// Pointers and count
	//////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Wrap at depth, also for depths that are not a power of two
			if (push)
				wrPtr <= (wrPtr == depth - 1) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == depth - 1) ? '0 : rdPtr + 1'b1;
			// Push and pop together keep the count
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Write port
	always_ff @(posedge PCLK)
	begin
		if (push)
			mem[wrPtr] <= pushIf.item;
	end

	// A write refused while full stays offered with the same byte
	pushHeldWhenFull: assert property (@(posedge PCLK) disable iff (!PRESETn)
		(pushIf.valid && !pushIf.ready) |=> (pushIf.valid && $stable(pushIf.item)));

	// Pointers meet only when the FIFO is empty or full
	ptrCountAgree: assert property (@(posedge PCLK) disable iff (!PRESETn)
		(wrPtr == rdPtr) == ((count == '0) || (count == depth)));

endmodule

// ==== i2cMaster.sv ====
//////////////////////////////
// I2C master bit engine, write only
// SCL divider, start, data, ACK, stop, NACK report
//////////////////////////////
`timescale 1ns/1ns

module i2cMaster
	import apbPkg::*, i2cPkg::*;
(
	input  logic                PCLK,
	input  logic                PRESETn,
	input  logic [divWidth-1:0] divider,
	input  logic                enable,
	input  logic                sdaIn,
	output logic                scl,
	output logic                sdaOut,
	output logic                sdaOe,
	output logic                busy,
	output logic                nackPulse,
	i2cByteIf.consumer          popIf
);

	i2cState_e           state;
	// Quarter period counter and quarter index
	logic [divWidth-1:0] qCnt;
	logic [1:0]          phase;
	logic [2:0]          bitCnt;
	logic [7:0]          shiftReg;
	logic                stopFlag;
	logic                running;
	logic                tick;
	logic                pop;

	// Quarters 0,1 with SCL low, 2,3 with SCL high
	assign running = (state != sIdle) && (state != sHold);
	assign tick    = running && (qCnt == divider);
	assign busy    = running;

	// Take a byte only when the bus is free or held
	assign popIf.ready = enable && ((state == sIdle) || (state == sHold));
	assign pop         = popIf.valid && popIf.ready;
	// One byte in flight while a transfer runs
	assign popIf.level = levelWidth'(busy);

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state     <= sIdle;
			qCnt      <= '0;
			phase     <= '0;
			bitCnt    <= '0;
			scl       <= 1'b1;
			sdaOut    <= 1'b1;
			sdaOe     <= 1'b0;
			nackPulse <= 1'b0;
		end
		else
		begin
			nackPulse <= 1'b0;
			if (pop)
			begin
				qCnt   <= '0;
				phase  <= '0;
				bitCnt <= '0;
				// Free bus always needs a start, held bus only on request
				if ((state == sIdle) || popIf.item.start)
				begin
					state  <= sStart;
					// Repeated start raises SDA while SCL is still low
					sdaOut <= 1'b1;
					sdaOe  <= 1'b1;
				end
				else
					state <= sBit;
			end
			else if (running)
			begin
				qCnt <= tick ? '0 : qCnt + 1'b1;
				if (tick)
				begin
					phase <= phase + 1'b1;
					case (state)
						sStart:
						begin
							// SCL high, then SDA falls, then SCL low
							if (phase == 2'd0)
								scl <= 1'b1;
							if (phase == 2'd1)
								sdaOut <= 1'b0;
							if (phase == 2'd3)
							begin
								scl   <= 1'b0;
								state <= sBit;
							end
						end
						sBit:
						begin
							// MSB first, SDA set in the middle of SCL low
							if (phase == 2'd0)
							begin
								sdaOut <= shiftReg[7];
								sdaOe  <= 1'b1;
							end
							if (phase == 2'd1)
								scl <= 1'b1;
							if (phase == 2'd3)
							begin
								scl <= 1'b0;
								if (bitCnt == 3'd7)
									state <= sAck;
								else
									bitCnt <= bitCnt + 1'b1;
							end
						end
						sAck:
						begin
							// Release SDA for the slave
							if (phase == 2'd0)
							begin
								sdaOut <= 1'b1;
								sdaOe  <= 1'b0;
							end
							if (phase == 2'd1)
								scl <= 1'b1;
							// Sample at the middle of SCL high
							if (phase == 2'd2)
								nackPulse <= sdaIn;
							if (phase == 2'd3)
							begin
								scl   <= 1'b0;
								state <= stopFlag ? sStop : sHold;
							end
						end
						sStop:
						begin
							// SDA low, SCL high, then SDA rises
							if (phase == 2'd0)
							begin
								sdaOut <= 1'b0;
								sdaOe  <= 1'b1;
							end
							if (phase == 2'd1)
								scl <= 1'b1;
							if (phase == 2'd2)
								sdaOut <= 1'b1;
							if (phase == 2'd3)
							begin
								sdaOe <= 1'b0;
								state <= sIdle;
							end
						end
						default:
							state <= state;
					endcase
				end
			end
		end
	end

	// Shift register and stop flag of the current byte
	always_ff @(posedge PCLK)
	begin
		if (pop)
		begin
			shiftReg <= popIf.item.data;
			stopFlag <= popIf.item.stop;
		end
		else if (tick && (state == sBit) && (phase == 2'd3))
			shiftReg <= {shiftReg[6:0], 1'b0};
	end

	// Data only moves with SCL low, start and stop excepted
	sdaStableHigh: assert property (@(posedge PCLK) disable iff (!PRESETn)
		(scl && $past(scl) && (state != sStart) && (state != sStop)) |-> $stable(sdaOut));

endmodule

// ==== apbI2cTop.sv ====
//////////////////////////////
// APB to I2C write master top level
//////////////////////////////
`timescale 1ns/1ns

module apbI2cTop
	import apbPkg::*;
(
	input  logic        PCLK,
	input  logic        PRESETn,
	// APB slave port
	input  logic        PSEL,
	input  logic        PENABLE,
	input  logic        PWRITE,
	input  logic [31:0] PADDR,
	input  logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic        PREADY,
	output logic        PSLVERR,
	output logic        irq,
	// I2C pins, SCL push-pull, SDA split for an external pad
	output logic        scl,
	output logic        sdaOut,
	output logic        sdaOe,
	input  logic        sdaIn
);

	// Config to the engine, status back
	logic [divWidth-1:0] divider;
	logic                enable;
	logic                busy;
	logic                nackPulse;

	// Register block to FIFO, FIFO to engine
	i2cByteIf pushIf ();
	i2cByteIf popIf ();

	apbRegs apbRegs_inst (
		.PCLK      (PCLK),
		.PRESETn   (PRESETn),
		.PSEL      (PSEL),
		.PENABLE   (PENABLE),
		.PWRITE    (PWRITE),
		.PADDR     (PADDR),
		.PWDATA    (PWDATA),
		.busy      (busy),
		.nackPulse (nackPulse),
		.PRDATA    (PRDATA),
		.PREADY    (PREADY),
		.PSLVERR   (PSLVERR),
		.divider   (divider),
		.enable    (enable),
		.irq       (irq),
		.pushIf    (pushIf.producer)
	);

	txFifo txFifo_inst (
		.PCLK    (PCLK),
		.PRESETn (PRESETn),
		.pushIf  (pushIf.consumer),
		.popIf   (popIf.producer)
	);

	i2cMaster i2cMaster_inst (
		.PCLK      (PCLK),
		.PRESETn   (PRESETn),
		.divider   (divider),
		.enable    (enable),
		.sdaIn     (sdaIn),
		.scl       (scl),
		.sdaOut    (sdaOut),
		.sdaOe     (sdaOe),
		.busy      (busy),
		.nackPulse (nackPulse),
		.popIf     (popIf.consumer)
	);

endmodule

// ==== tbApbI2c.sv ====
//////////////////////////////
// Testbench for the APB to I2C write master
// APB driver, register table, I2C slave model, compare tasks
//////////////////////////////
`timescale 1ns/1ns

module tbApbI2c
	import apbPkg::*, i2cPkg::*;
();

	// One register access and its expected response
	typedef struct packed {
		logic        write;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic        err;
	} regStep_t;

	localparam int readyLimit = 5000;
	localparam int rxLimit    = 40000;
	localparam int pollLimit  = 2000;
	localparam int numSteps   = 16;
	// Enable bit alone, and every config bit
	localparam logic [31:0] enableWord = 32'd1 << cfgEnableBit;
	localparam logic [31:0] cfgAll     = enableWord | ((32'd1 << divWidth) - 32'd1);
	localparam logic [31:0] emptyWord  = 32'd1 << stTxEmpty;

	// Reset values, field masking, unmapped offsets
	localparam regStep_t regTable [numSteps] = '{
		'{1'b0, addrStatus,  32'd0,        emptyWord, 1'b0},
		'{1'b0, addrConfig,  32'd0,        32'd0,     1'b0},
		'{1'b0, addrIrqMask, 32'd0,        32'd0,     1'b0},
		'{1'b0, addrTxData,  32'd0,        32'd0,     1'b0},
		'{1'b1, addrConfig,  32'hFFFFFFFF, 32'd0,     1'b0},
		'{1'b0, addrConfig,  32'd0,        cfgAll,    1'b0},
		'{1'b1, addrIrqMask, 32'hFFFFFFFF, 32'd0,     1'b0},
		'{1'b0, addrIrqMask, 32'd0,        32'd3,     1'b0},
		'{1'b1, 32'd16,      32'h12345678, 32'd0,     1'b1},
		'{1'b0, 32'd16,      32'd0,        32'd0,     1'b1},
		'{1'b1, 32'h40,      32'h00000000, 32'd0,     1'b1},
		'{1'b0, addrConfig,  32'd0,        cfgAll,    1'b0},
		'{1'b0, addrIrqMask, 32'd0,        32'd3,     1'b0},
		'{1'b1, addrConfig,  32'd0,        32'd0,     1'b0},
		'{1'b1, addrIrqMask, 32'd0,        32'd0,     1'b0},
		'{1'b0, addrConfig,  32'd0,        32'd0,     1'b0}
	};

	logic        PCLK = 1'b0;
	logic        PRESETn;
	logic        PSEL;
	logic        PENABLE;
	logic        PWRITE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic        PREADY;
	logic        PSLVERR;
	logic        irq;
	logic        scl;
	logic        sdaOut;
	logic        sdaOe;
	logic        sdaIn = 1'b1;

	integer      seed = 32'h5aa70220;
	logic        waitSeen;
	logic        lastIrq;
	logic        busFree = 1'b1;
	i2cByte_t    expQ [$];
	i2cByte_t    rxQ [$];

	// Slave model state
	logic        prevScl = 1'b1;
	logic        prevSda = 1'b1;
	logic        curScl;
	logic        curSda;
	logic        highSda;
	logic        condInHigh = 1'b0;
	logic        startPending = 1'b0;
	logic        sdaDrive = 1'b1;
	logic [7:0]  shifter;
	int          bitPos = 0;
	int          rxTotal = 0;
	logic        nackAt [64] = '{default: 1'b0};
	i2cByte_t    monItem;

	apbI2cTop apbI2cTop_inst (
		.PCLK    (PCLK),
		.PRESETn (PRESETn),
		.PSEL    (PSEL),
		.PENABLE (PENABLE),
		.PWRITE  (PWRITE),
		.PADDR   (PADDR),
		.PWDATA  (PWDATA),
		.PRDATA  (PRDATA),
		.PREADY  (PREADY),
		.PSLVERR (PSLVERR),
		.irq     (irq),
		.scl     (scl),
		.sdaOut  (sdaOut),
		.sdaOe   (sdaOe),
		.sdaIn   (sdaIn)
	);

	// 4 ns clock
	always #2 PCLK = ~PCLK;

	//////////////////////////////
	// Failure reporting and compares
	//////////////////////////////

	task automatic stopRun();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic reportFailure(input string msg);
		$display("%0t ns: %s", $time, msg);
		stopRun();
	endtask

	task automatic checkWord(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (actVal !== expVal)
		begin
			$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
			stopRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal)
		begin
			$display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expVal, actVal);
			stopRun();
		end
	endtask

	// Data plus start/stop framing
	task automatic checkByte(input string name, input i2cByte_t expVal, input i2cByte_t actVal);
		if (actVal !== expVal)
		begin
			$display("ERROR at %0t ns: %s expected %h start %b stop %b, got %h start %b stop %b",
				$time, name, expVal.data, expVal.start, expVal.stop,
				actVal.data, actVal.start, actVal.stop);
			stopRun();
		end
	endtask

	//////////////////////////////
	// APB driver
	//////////////////////////////

	// Setup, access, then wait states until PREADY, sampled at negedge
	task automatic apbAccess(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int cycles;
		@(posedge PCLK);
		PSEL    <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE  <= wr;
		PADDR   <= addr;
		PWDATA  <= wdata;
		@(posedge PCLK);
		PENABLE <= 1'b1;
		cycles = 0;
		@(negedge PCLK);
		while (!PREADY && (cycles < readyLimit))
		begin
			waitSeen = 1'b1;
			cycles++;
			@(negedge PCLK);
		end
		if (!PREADY)
			reportFailure($sformatf("timeout waiting for PREADY at offset %0h", addr));
		rdata   = PRDATA;
		err     = PSLVERR;
		lastIrq = irq;
		// Access completes on this edge
		@(posedge PCLK);
		PSEL    <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	// Push one byte and record what the bus should show
	task automatic queueByte(input logic [7:0] data, input logic startFlag, input logic stopFlag);
		logic [31:0] word;
		logic [31:0] rd;
		logic        err;
		i2cByte_t    item;
		word             = 32'(data);
		word[txStartBit] = startFlag;
		word[txStopBit]  = stopFlag;
		apbAccess(1'b1, addrTxData, word, rd, err);
		checkFlag("PSLVERR", 1'b0, err);
		item.data  = data;
		// Engine issues a start by itself on a free bus
		item.start = startFlag || busFree;
		item.stop  = stopFlag;
		expQ.push_back(item);
		busFree = stopFlag;
	endtask

	task automatic waitRxCount(input int count);
		int cycles;
		cycles = 0;
		while ((rxQ.size() < count) && (cycles < rxLimit))
		begin
			@(posedge PCLK);
			cycles++;
		end
		if (rxQ.size() < count)
			reportFailure($sformatf("timeout waiting for %0d bytes on the I2C bus, got %0d",
				count, rxQ.size()));
	endtask

	// Poll status until nothing is queued or in flight
	task automatic waitTxEmpty(output logic [31:0] status);
		logic err;
		int   polls;
		polls = 0;
		apbAccess(1'b0, addrStatus, 32'd0, status, err);
		while (!status[stTxEmpty] && (polls < pollLimit))
		begin
			polls++;
			apbAccess(1'b0, addrStatus, 32'd0, status, err);
		end
		if (!status[stTxEmpty])
			reportFailure("timeout waiting for status txEmpty");
	endtask

	task automatic compareReceived();
		logic [31:0] status;
		i2cByte_t    expItem;
		i2cByte_t    rxItem;
		waitRxCount(expQ.size());
		waitTxEmpty(status);
		if (rxQ.size() != expQ.size())
			reportFailure($sformatf("slave received %0d bytes, %0d were written",
				rxQ.size(), expQ.size()));
		while (expQ.size() > 0)
		begin
			expItem = expQ.pop_front();
			rxItem  = rxQ.pop_front();
			checkByte("I2C byte", expItem, rxItem);
		end
	endtask

	//////////////////////////////
	// I2C slave model
	//////////////////////////////

	// ACK or NACK onto sdaIn, rising edge
	always @(posedge PCLK)
		sdaIn <= sdaDrive;

	// Bits taken when SCL falls, unless a start or stop hit that high phase
	always @(negedge PCLK)
	begin
		curScl = scl;
		// Released SDA reads high through the pull-up
		curSda = sdaOe ? sdaOut : 1'b1;
		if (PRESETn)
		begin
			if (prevScl && curScl && (prevSda != curSda))
			begin
				condInHigh = 1'b1;
				if (bitPos != 0)
					reportFailure("SDA changed while SCL was high inside a byte");
				if (!curSda)
					startPending = 1'b1;
				else if (rxQ.size() == 0)
					reportFailure("stop condition without a received byte");
				else
				begin
					monItem      = rxQ.pop_back();
					monItem.stop = 1'b1;
					rxQ.push_back(monItem);
				end
			end
			else if (!prevScl && curScl)
			begin
				highSda    = curSda;
				condInHigh = 1'b0;
			end
			else if (prevScl && !curScl && !condInHigh)
			begin
				if (bitPos < 8)
				begin
					shifter = {shifter[6:0], highSda};
					bitPos++;
					if (bitPos == 8)
					begin
						monItem.data  = shifter;
						monItem.start = startPending;
						monItem.stop  = 1'b0;
						rxQ.push_back(monItem);
						startPending = 1'b0;
						// Answer for this byte, 1 is a NACK
						sdaDrive = (rxTotal < 64) ? nackAt[rxTotal] : 1'b0;
						rxTotal++;
					end
				end
				else
				begin
					// Ninth clock done, release SDA
					sdaDrive = 1'b1;
					bitPos   = 0;
				end
			end
		end
		prevScl = curScl;
		prevSda = curSda;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		logic [31:0] rd;
		logic [31:0] status;
		logic        err;
		int          i;
		PRESETn  <= 1'b0;
		PSEL     <= 1'b0;
		PENABLE  <= 1'b0;
		PWRITE   <= 1'b0;
		PADDR    <= '0;
		PWDATA   <= '0;
		waitSeen = 1'b0;
		repeat (10) @(posedge PCLK);
		PRESETn <= 1'b1;

		// Idle after reset
		@(negedge PCLK);
		checkFlag("irq", 1'b0, irq);
		checkFlag("PREADY", 1'b0, PREADY);
		checkFlag("scl", 1'b1, scl);
		checkFlag("sdaOe", 1'b0, sdaOe);

		// Register table
		for (i = 0; i < numSteps; i++)
		begin
			apbAccess(regTable[i].write, regTable[i].addr, regTable[i].wdata, rd, err);
			checkFlag("PSLVERR", regTable[i].err, err);
			if (!regTable[i].write && !regTable[i].err)
				checkWord("PRDATA", regTable[i].rdata, rd);
		end

		// Framing, held bus and repeated start
		apbAccess(1'b1, addrConfig, enableWord | 32'd2, rd, err);
		queueByte(8'($random(seed)), 1'b1, 1'b0);
		queueByte(8'($random(seed)), 1'b0, 1'b0);
		queueByte(8'($random(seed)), 1'b1, 1'b0);
		queueByte(8'($random(seed)), 1'b0, 1'b1);
		compareReceived();
		// No start flag on a free bus
		queueByte(8'($random(seed)), 1'b0, 1'b1);
		compareReceived();

		// Slow bus, more bytes than the FIFO holds
		apbAccess(1'b1, addrConfig, enableWord | 32'd40, rd, err);
		waitSeen = 1'b0;
		for (i = 0; i < fifoDepth + 2; i++)
			queueByte(8'($random(seed)), i == 0, i == fifoDepth + 1);
		if (!waitSeen)
			reportFailure("no wait state seen while writing into a full FIFO");
		compareReceived();

		// NACK on one byte, irq through mask bit 1
		apbAccess(1'b1, addrIrqMask, 32'd2, rd, err);
		nackAt[rxTotal] = 1'b1;
		queueByte(8'($random(seed)), 1'b1, 1'b1);
		compareReceived();
		apbAccess(1'b0, addrStatus, 32'd0, rd, err);
		checkWord("status", emptyWord | (32'd1 << stNack), rd);
		checkFlag("irq", 1'b1, lastIrq);
		apbAccess(1'b1, addrStatus, 32'd1 << stNack, rd, err);
		apbAccess(1'b0, addrStatus, 32'd0, rd, err);
		checkWord("status", emptyWord, rd);
		checkFlag("irq", 1'b0, lastIrq);

		// Empty interrupt through mask bit 0
		apbAccess(1'b1, addrIrqMask, 32'd1, rd, err);
		// Mask register settles on the completing edge
		@(negedge PCLK);
		checkFlag("irq", 1'b1, irq);
		queueByte(8'($random(seed)), 1'b1, 1'b0);
		queueByte(8'($random(seed)), 1'b0, 1'b1);
		apbAccess(1'b0, addrStatus, 32'd0, rd, err);
		checkFlag("status txEmpty", 1'b0, rd[stTxEmpty]);
		checkFlag("irq", 1'b0, lastIrq);
		waitTxEmpty(status);
		checkFlag("irq", 1'b1, lastIrq);
		compareReceived();

		$display("Test OK");
		$finish;
	end

endmodule

// ==== all.f ====
apbPkg.sv
i2cPkg.sv
i2cByteIf.sv
apbRegs.sv
txFifo.sv
i2cMaster.sv
apbI2cTop.sv
tbApbI2c.sv

// ==== Makefile ====
# Verilator build and run for the APB to I2C master testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tbApbI2c
FILELIST = all.f
PASS_MSG = Test OK

BUILD = obj_dir
BIN   = $(BUILD)/V$(TOP)
SRCS  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

# Fails unless the pass message appears in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
